//--- hdl/iagc_ctrl_pkg.sv
`default_nettype none

package iagc_ctrl_pkg;

    localparam int STATUS_W = 4;
    localparam int CMD_W    = 4;

    // status codes
    localparam logic [STATUS_W-1:0] ST_RESET     = 4'd0;
    localparam logic [STATUS_W-1:0] ST_INIT      = 4'd1;
    localparam logic [STATUS_W-1:0] ST_IDLE      = 4'd2;
    localparam logic [STATUS_W-1:0] ST_SAMPLE    = 4'd3;
    localparam logic [STATUS_W-1:0] ST_CMD_PARSE = 4'd4;
    localparam logic [STATUS_W-1:0] ST_CMD_READ  = 4'd5;
    localparam logic [STATUS_W-1:0] ST_CMD_ERROR = 4'd6;
    localparam logic [STATUS_W-1:0] ST_DUMP      = 4'd7;
    localparam logic [STATUS_W-1:0] ST_CLEAN     = 4'd8;
    localparam logic [STATUS_W-1:0] ST_SET_MEM   = 4'd9;
    localparam logic [STATUS_W-1:0] ST_SET_DEC   = 4'd10;
    localparam logic [STATUS_W-1:0] ST_HALT      = 4'd11;

    // host operations, 8 to 15 are invalid
    localparam logic [CMD_W-1:0] CMD_EMPTY   = 4'd0;
    localparam logic [CMD_W-1:0] CMD_RESET   = 4'd1;
    localparam logic [CMD_W-1:0] CMD_SAMPLE  = 4'd2;
    localparam logic [CMD_W-1:0] CMD_SET_DEC = 4'd3;
    localparam logic [CMD_W-1:0] CMD_CLEAN   = 4'd4;
    localparam logic [CMD_W-1:0] CMD_DUMP    = 4'd5;
    localparam logic [CMD_W-1:0] CMD_SET_MEM = 4'd6;
    localparam logic [CMD_W-1:0] CMD_HALT    = 4'd7;

endpackage

`default_nettype wire

//--- hdl/iagc_data_pkg.sv
`default_nettype none

package iagc_data_pkg;

    localparam int SAMPLE_W  = 14;
    localparam int ADDR_W    = 8;
    localparam int MEM_DEPTH = 1 << ADDR_W;
    // one extra bit so a full buffer can be counted
    localparam int SIZE_W    = ADDR_W + 1;

    localparam int DEF_MEM_LOG2  = 6;
    localparam int DEF_DECIMATOR = 4;

    localparam int DUMP_CREDITS = 4;
    localparam int CREDIT_W     = $clog2(DUMP_CREDITS + 1);

endpackage

`default_nettype wire

//--- hdl/iagc_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module iagc_fsm (
    input  wire logic                                i_clock,
    input  wire logic                                i_reset,
    input  wire logic                                i_adc_init_done,
    input  wire logic                                i_sample,
    input  wire logic                                i_cmd_valid,
    input  wire logic [iagc_ctrl_pkg::CMD_W-1:0]     i_cmd_operation,
    input  wire logic [iagc_ctrl_pkg::CMD_W-1:0]     i_cmd_parameter,
    input  wire logic                                i_sample_end,
    input  wire logic                                i_clean_end,
    input  wire logic                                i_dump_end,
    output logic      [iagc_ctrl_pkg::STATUS_W-1:0]  o_status,
    output logic      [iagc_data_pkg::SIZE_W-1:0]    o_memory_size,
    output logic      [iagc_ctrl_pkg::CMD_W-1:0]     o_decimator
);

    logic [iagc_ctrl_pkg::STATUS_W-1:0] status;
    logic [iagc_ctrl_pkg::STATUS_W-1:0] next_status;
    logic [iagc_ctrl_pkg::CMD_W-1:0]    cmd_op;
    logic [iagc_ctrl_pkg::CMD_W-1:0]    cmd_param;
    logic [iagc_ctrl_pkg::CMD_W-1:0]    mem_log2;
    logic [iagc_data_pkg::SIZE_W-1:0]   memory_size;
    logic [iagc_ctrl_pkg::CMD_W-1:0]    decimator;

    // exponent saturates at the full buffer
    assign mem_log2 = (cmd_param > iagc_ctrl_pkg::CMD_W'(iagc_data_pkg::ADDR_W)) ?
                      iagc_ctrl_pkg::CMD_W'(iagc_data_pkg::ADDR_W) : cmd_param;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            status      <= iagc_ctrl_pkg::ST_RESET;
            memory_size <= iagc_data_pkg::SIZE_W'(1) << iagc_data_pkg::DEF_MEM_LOG2;
            decimator   <= iagc_ctrl_pkg::CMD_W'(iagc_data_pkg::DEF_DECIMATOR);
        end else begin
            status <= next_status;
            if (status == iagc_ctrl_pkg::ST_SET_MEM) begin
                memory_size <= iagc_data_pkg::SIZE_W'(1) << mem_log2;
            end
            if (status == iagc_ctrl_pkg::ST_SET_DEC) begin
                decimator <= cmd_param;
            end
        end
    end

    // command is captured only when idle
    always_ff @(posedge i_clock) begin
        if (status == iagc_ctrl_pkg::ST_IDLE && i_cmd_valid) begin
            cmd_op    <= i_cmd_operation;
            cmd_param <= i_cmd_parameter;
        end
    end

    always_comb begin
        case (status)
            iagc_ctrl_pkg::ST_RESET:     next_status = iagc_ctrl_pkg::ST_INIT;
            iagc_ctrl_pkg::ST_INIT: begin
                next_status = i_adc_init_done ? iagc_ctrl_pkg::ST_IDLE : iagc_ctrl_pkg::ST_INIT;
            end
            iagc_ctrl_pkg::ST_IDLE: begin
                if (i_cmd_valid) begin
                    next_status = iagc_ctrl_pkg::ST_CMD_PARSE;
                end else if (i_sample) begin
                    next_status = iagc_ctrl_pkg::ST_SAMPLE;
                end else begin
                    next_status = iagc_ctrl_pkg::ST_IDLE;
                end
            end
            iagc_ctrl_pkg::ST_SAMPLE: begin
                next_status = i_sample_end ? iagc_ctrl_pkg::ST_IDLE : iagc_ctrl_pkg::ST_SAMPLE;
            end
            iagc_ctrl_pkg::ST_CMD_PARSE: next_status = iagc_ctrl_pkg::ST_CMD_READ;
            iagc_ctrl_pkg::ST_CMD_READ: begin
                case (cmd_op)
                    iagc_ctrl_pkg::CMD_EMPTY:   next_status = iagc_ctrl_pkg::ST_IDLE;
                    iagc_ctrl_pkg::CMD_RESET:   next_status = iagc_ctrl_pkg::ST_RESET;
                    iagc_ctrl_pkg::CMD_SAMPLE:  next_status = iagc_ctrl_pkg::ST_SAMPLE;
                    iagc_ctrl_pkg::CMD_SET_DEC: next_status = iagc_ctrl_pkg::ST_SET_DEC;
                    iagc_ctrl_pkg::CMD_CLEAN:   next_status = iagc_ctrl_pkg::ST_CLEAN;
                    iagc_ctrl_pkg::CMD_DUMP:    next_status = iagc_ctrl_pkg::ST_DUMP;
                    iagc_ctrl_pkg::CMD_SET_MEM: next_status = iagc_ctrl_pkg::ST_SET_MEM;
                    iagc_ctrl_pkg::CMD_HALT:    next_status = iagc_ctrl_pkg::ST_HALT;
                    default:                    next_status = iagc_ctrl_pkg::ST_CMD_ERROR;
                endcase
            end
            iagc_ctrl_pkg::ST_CMD_ERROR: next_status = iagc_ctrl_pkg::ST_IDLE;
            iagc_ctrl_pkg::ST_DUMP: begin
                next_status = i_dump_end ? iagc_ctrl_pkg::ST_IDLE : iagc_ctrl_pkg::ST_DUMP;
            end
            iagc_ctrl_pkg::ST_CLEAN: begin
                next_status = i_clean_end ? iagc_ctrl_pkg::ST_IDLE : iagc_ctrl_pkg::ST_CLEAN;
            end
            iagc_ctrl_pkg::ST_SET_MEM:   next_status = iagc_ctrl_pkg::ST_IDLE;
            iagc_ctrl_pkg::ST_SET_DEC:   next_status = iagc_ctrl_pkg::ST_IDLE;
            // only i_reset leaves halt
            iagc_ctrl_pkg::ST_HALT:      next_status = iagc_ctrl_pkg::ST_HALT;
            default:                     next_status = iagc_ctrl_pkg::ST_RESET;
        endcase
    end

    assign o_status      = status;
    assign o_memory_size = memory_size;
    assign o_decimator   = decimator;

    a_status_defined: assert property (@(posedge i_clock) disable iff (i_reset)
        status <= iagc_ctrl_pkg::ST_HALT)
        else $error("undefined status code %0d", status);

endmodule

`default_nettype wire

//--- hdl/sample_decimator.sv
`timescale 1ns/10ps
`default_nettype none

module sample_decimator (
    input  wire logic                                i_clock,
    input  wire logic                                i_reset,
    input  wire logic [iagc_ctrl_pkg::STATUS_W-1:0]  i_status,
    input  wire logic [iagc_ctrl_pkg::CMD_W-1:0]     i_decimator,
    input  wire logic                                i_adc_valid,
    input  wire logic [iagc_data_pkg::SAMPLE_W-1:0]  i_adc_data,
    output logic                                     o_wr_valid,
    output logic      [iagc_data_pkg::SAMPLE_W-1:0]  o_wr_data
);

    logic                             sampling;
    logic                             keep;
    logic [iagc_ctrl_pkg::CMD_W-1:0]  countdown;
    logic [iagc_ctrl_pkg::CMD_W-1:0]  reload;

    assign sampling = (i_status == iagc_ctrl_pkg::ST_SAMPLE);
    // zero behaves as one, keep every sample
    assign reload = (i_decimator == '0) ? '0 : i_decimator - iagc_ctrl_pkg::CMD_W'(1);
    assign keep = sampling && i_adc_valid && (countdown == '0);

    // held at zero outside sampling so the first valid is kept
    always_ff @(posedge i_clock) begin
        if (i_reset || !sampling) begin
            countdown <= '0;
        end else if (i_adc_valid) begin
            countdown <= keep ? reload : countdown - iagc_ctrl_pkg::CMD_W'(1);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_wr_valid <= 1'b0;
        end else begin
            o_wr_valid <= keep;
        end
    end

    always_ff @(posedge i_clock) begin
        if (keep) begin
            o_wr_data <= i_adc_data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/sample_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module sample_buffer (
    input  wire logic                                i_clock,
    input  wire logic                                i_reset,
    input  wire logic [iagc_ctrl_pkg::STATUS_W-1:0]  i_status,
    input  wire logic [iagc_data_pkg::SIZE_W-1:0]    i_memory_size,
    input  wire logic                                i_wr_valid,
    input  wire logic [iagc_data_pkg::SAMPLE_W-1:0]  i_wr_data,
    input  wire logic                                i_rd_req,
    output logic                                     o_sample_end,
    output logic                                     o_clean_end,
    output logic                                     o_rd_valid,
    output logic      [iagc_data_pkg::SAMPLE_W-1:0]  o_rd_data,
    output logic                                     o_rd_last
);

    logic [iagc_data_pkg::SAMPLE_W-1:0] mem [0:iagc_data_pkg::MEM_DEPTH-1];
    logic                               is_sample;
    logic                               is_clean;
    logic                               is_dump;
    logic [iagc_data_pkg::SIZE_W-1:0]   wr_ptr;
    logic [iagc_data_pkg::SIZE_W-1:0]   rd_ptr;
    logic [iagc_data_pkg::SIZE_W-1:0]   last_addr;
    logic                               mem_we;
    logic [iagc_data_pkg::SAMPLE_W-1:0] mem_wdata;
    logic                               rd_en;

    assign is_sample = (i_status == iagc_ctrl_pkg::ST_SAMPLE);
    assign is_clean  = (i_status == iagc_ctrl_pkg::ST_CLEAN);
    assign is_dump   = (i_status == iagc_ctrl_pkg::ST_DUMP);
    assign last_addr = i_memory_size - iagc_data_pkg::SIZE_W'(1);

    // clean writes every cycle, sampling only on a strobe
    assign mem_we = (is_clean || (is_sample && i_wr_valid)) && (wr_ptr < i_memory_size);
    assign mem_wdata = is_clean ? '0 : i_wr_data;

    // buffer full, strobes from here on are dropped
    assign o_sample_end = is_sample && (wr_ptr == i_memory_size);
    assign o_clean_end  = is_clean && (wr_ptr == last_addr);

    assign rd_en = is_dump && i_rd_req && (rd_ptr < i_memory_size);

    always_ff @(posedge i_clock) begin
        if (i_reset || !(is_sample || is_clean)) begin
            wr_ptr <= '0;
        end else if (mem_we) begin
            wr_ptr <= wr_ptr + iagc_data_pkg::SIZE_W'(1);
        end
    end

    always_ff @(posedge i_clock) begin
        if (mem_we) begin
            mem[wr_ptr[iagc_data_pkg::ADDR_W-1:0]] <= mem_wdata;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rd_ptr     <= '0;
            o_rd_valid <= 1'b0;
            o_rd_last  <= 1'b0;
        end else begin
            o_rd_valid <= rd_en;
            o_rd_last  <= rd_en && (rd_ptr == last_addr);
            if (!is_dump) begin
                rd_ptr <= '0;
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + iagc_data_pkg::SIZE_W'(1);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (rd_en) begin
            o_rd_data <= mem[rd_ptr[iagc_data_pkg::ADDR_W-1:0]];
        end
    end

    // holds only while the FSM keeps the size fixed during a fill
    a_no_write_past_size: assert property (@(posedge i_clock) disable iff (i_reset)
        (is_sample || is_clean) |-> wr_ptr <= i_memory_size)
        else $error("write pointer %0d beyond memory size %0d", wr_ptr, i_memory_size);

endmodule

`default_nettype wire

//--- hdl/dump_sender.sv
`timescale 1ns/10ps
`default_nettype none

module dump_sender (
    input  wire logic                                i_clock,
    input  wire logic                                i_reset,
    input  wire logic [iagc_ctrl_pkg::STATUS_W-1:0]  i_status,
    input  wire logic                                i_rd_valid,
    input  wire logic [iagc_data_pkg::SAMPLE_W-1:0]  i_rd_data,
    input  wire logic                                i_rd_last,
    input  wire logic                                i_dump_credit,
    output logic                                     o_rd_req,
    output logic                                     o_dump_end,
    output logic                                     o_dump_valid,
    output logic      [iagc_data_pkg::SAMPLE_W-1:0]  o_dump_data
);

    logic                                 is_dump;
    logic [iagc_data_pkg::CREDIT_W-1:0]   credits;
    logic [iagc_data_pkg::CREDIT_W-1:0]   inflight;
    logic                                 last_seen;
    logic                                 credit_ret;

    assign is_dump = (i_status == iagc_ctrl_pkg::ST_DUMP);

    // reads in flight hold a credit until their word goes out
    assign o_rd_req = is_dump && !last_seen && (credits > inflight);

    // a return is lost only when full and nothing is spent
    assign credit_ret = i_dump_credit &&
        ((credits != iagc_data_pkg::CREDIT_W'(iagc_data_pkg::DUMP_CREDITS)) || o_dump_valid);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            credits <= iagc_data_pkg::CREDIT_W'(iagc_data_pkg::DUMP_CREDITS);
        end else if (credit_ret && !o_dump_valid) begin
            credits <= credits + iagc_data_pkg::CREDIT_W'(1);
        end else if (!credit_ret && o_dump_valid) begin
            credits <= credits - iagc_data_pkg::CREDIT_W'(1);
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || !is_dump) begin
            inflight  <= '0;
            last_seen <= 1'b0;
        end else begin
            inflight <= inflight + iagc_data_pkg::CREDIT_W'(o_rd_req)
                                 - iagc_data_pkg::CREDIT_W'(o_dump_valid);
            if (i_rd_valid && i_rd_last) begin
                last_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_dump_valid <= 1'b0;
            o_dump_end   <= 1'b0;
        end else begin
            o_dump_valid <= i_rd_valid;
            o_dump_end   <= i_rd_valid && i_rd_last;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rd_valid) begin
            o_dump_data <= i_rd_data;
        end
    end

    a_credit_bound: assert property (@(posedge i_clock) disable iff (i_reset)
        credits <= iagc_data_pkg::CREDIT_W'(iagc_data_pkg::DUMP_CREDITS))
        else $error("credit count %0d above limit", credits);

    a_send_needs_credit: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_valid |-> credits != '0)
        else $error("dump word sent without a credit");

endmodule

`default_nettype wire

//--- hdl/iagc_top.sv
`timescale 1ns/10ps
`default_nettype none

module iagc_top (
    input  wire logic                                i_clock,
    input  wire logic                                i_reset,
    input  wire logic                                i_adc_init_done,
    input  wire logic                                i_adc_valid,
    input  wire logic [iagc_data_pkg::SAMPLE_W-1:0]  i_adc_data,
    input  wire logic                                i_sample,
    input  wire logic                                i_cmd_valid,
    input  wire logic [iagc_ctrl_pkg::CMD_W-1:0]     i_cmd_operation,
    input  wire logic [iagc_ctrl_pkg::CMD_W-1:0]     i_cmd_parameter,
    input  wire logic                                i_dump_credit,
    output logic      [iagc_ctrl_pkg::STATUS_W-1:0]  o_status,
    output logic      [iagc_data_pkg::SIZE_W-1:0]    o_memory_size,
    output logic      [iagc_ctrl_pkg::CMD_W-1:0]     o_decimator,
    output logic                                     o_dump_valid,
    output logic      [iagc_data_pkg::SAMPLE_W-1:0]  o_dump_data
);

    logic                               sample_end;
    logic                               clean_end;
    logic                               dump_end;
    logic                               wr_valid;
    logic [iagc_data_pkg::SAMPLE_W-1:0] wr_data;
    logic                               rd_req;
    logic                               rd_valid;
    logic [iagc_data_pkg::SAMPLE_W-1:0] rd_data;
    logic                               rd_last;

    iagc_fsm u_fsm (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_adc_init_done (i_adc_init_done),
        .i_sample        (i_sample),
        .i_cmd_valid     (i_cmd_valid),
        .i_cmd_operation (i_cmd_operation),
        .i_cmd_parameter (i_cmd_parameter),
        .i_sample_end    (sample_end),
        .i_clean_end     (clean_end),
        .i_dump_end      (dump_end),
        .o_status        (o_status),
        .o_memory_size   (o_memory_size),
        .o_decimator     (o_decimator)
    );

    sample_decimator u_decimator (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_status    (o_status),
        .i_decimator (o_decimator),
        .i_adc_valid (i_adc_valid),
        .i_adc_data  (i_adc_data),
        .o_wr_valid  (wr_valid),
        .o_wr_data   (wr_data)
    );

    sample_buffer u_buffer (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_status      (o_status),
        .i_memory_size (o_memory_size),
        .i_wr_valid    (wr_valid),
        .i_wr_data     (wr_data),
        .i_rd_req      (rd_req),
        .o_sample_end  (sample_end),
        .o_clean_end   (clean_end),
        .o_rd_valid    (rd_valid),
        .o_rd_data     (rd_data),
        .o_rd_last     (rd_last)
    );

    dump_sender u_sender (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_status      (o_status),
        .i_rd_valid    (rd_valid),
        .i_rd_data     (rd_data),
        .i_rd_last     (rd_last),
        .i_dump_credit (i_dump_credit),
        .o_rd_req      (rd_req),
        .o_dump_end    (dump_end),
        .o_dump_valid  (o_dump_valid),
        .o_dump_data   (o_dump_data)
    );

endmodule

`default_nettype wire

//--- verif/iagc_tb.sv
`timescale 1ns/10ps
`default_nettype none

module iagc_tb;

    logic                                clock = 1'b0;
    logic                                reset;
    logic                                adc_init_done;
    logic                                adc_valid;
    logic [iagc_data_pkg::SAMPLE_W-1:0]  adc_data;
    logic                                sample;
    logic                                cmd_valid;
    logic [iagc_ctrl_pkg::CMD_W-1:0]     cmd_operation;
    logic [iagc_ctrl_pkg::CMD_W-1:0]     cmd_parameter;
    logic                                dump_credit;
    logic [iagc_ctrl_pkg::STATUS_W-1:0]  status;
    logic [iagc_data_pkg::SIZE_W-1:0]    memory_size;
    logic [iagc_ctrl_pkg::CMD_W-1:0]     decimator;
    logic                                dump_valid;
    logic [iagc_data_pkg::SAMPLE_W-1:0]  dump_data;

    // reference model of the buffer contents and the credit loop
    logic [iagc_data_pkg::SAMPLE_W-1:0]  model_mem [0:iagc_data_pkg::MEM_DEPTH-1];
    logic [iagc_ctrl_pkg::STATUS_W-1:0]  last_status;
    logic [iagc_data_pkg::SAMPLE_W-1:0]  ramp;
    logic                                adc_enable;
    logic                                credit_enable;
    string                               test_name;
    int                                  valid_count;
    int                                  stored_words;
    int                                  dump_words;
    int                                  sent_total;
    int                                  returned_total;
    // settings the commands so far should have left behind
    int                                  exp_mem_size;
    int                                  exp_decimator;

    iagc_top DUT (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_adc_init_done (adc_init_done),
        .i_adc_valid     (adc_valid),
        .i_adc_data      (adc_data),
        .i_sample        (sample),
        .i_cmd_valid     (cmd_valid),
        .i_cmd_operation (cmd_operation),
        .i_cmd_parameter (cmd_parameter),
        .i_dump_credit   (dump_credit),
        .o_status        (status),
        .o_memory_size   (memory_size),
        .o_decimator     (decimator),
        .o_dump_valid    (dump_valid),
        .o_dump_data     (dump_data)
    );

    always #50 clock = ~clock;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_equal(input string what, input int expected, input int actual);
        assert (actual == expected)
        else stop_with_failure($sformatf("MISMATCH %s %s: expected %0d, actual %0d",
                                         test_name, what, expected, actual));
    endtask

    task automatic check_status(input logic [iagc_ctrl_pkg::STATUS_W-1:0] expected);
        assert (status == expected)
        else stop_with_failure($sformatf("MISMATCH %s status: expected %0d, actual %0d",
                                         test_name, expected, status));
    endtask

    task automatic wait_for_status(input logic [iagc_ctrl_pkg::STATUS_W-1:0] target,
                                   input int limit);
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
            if (n > limit) begin
                stop_with_failure($sformatf("timeout in %s waiting for status %0d",
                                            test_name, target));
            end
        end while (status != target);
    endtask

    // the model counts words on the falling edge
    task automatic wait_for_dump_words(input int count, input int limit);
        int n;
        n = 0;
        while (dump_words < count) begin
            @(posedge clock);
            n++;
            if (n > limit) begin
                stop_with_failure($sformatf("timeout in %s waiting for %0d dump words",
                                            test_name, count));
            end
        end
    endtask

    task automatic send_command(input logic [iagc_ctrl_pkg::CMD_W-1:0] op,
                                input logic [iagc_ctrl_pkg::CMD_W-1:0] param);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 200);
        @(posedge clock);
        cmd_valid     <= 1'b1;
        cmd_operation <= op;
        cmd_parameter <= param;
        @(posedge clock);
        cmd_valid     <= 1'b0;
    endtask

    // ADC valid gaps and credit returns share one seeded generator
    initial begin : random_drivers
        void'($urandom(89));
        adc_valid   <= 1'b0;
        adc_data    <= '0;
        dump_credit <= 1'b0;
        ramp        <= '0;
        forever begin
            @(posedge clock);
            if (adc_enable && ($urandom % 4) != 0) begin
                adc_valid <= 1'b1;
                adc_data  <= ramp;
                ramp      <= ramp + iagc_data_pkg::SAMPLE_W'(1);
            end else begin
                adc_valid <= 1'b0;
            end
            dump_credit <= credit_enable && (($urandom % 2) == 0);
        end
    end

    always @(negedge clock) begin : reference_model
        int dec;
        int size;
        int outstanding;
        int a;
        if (reset) begin
            valid_count    = 0;
            stored_words   = 0;
            dump_words     = 0;
            sent_total     = 0;
            returned_total = 0;
        end else begin
            dec  = (exp_decimator == 0) ? 1 : exp_decimator;
            size = exp_mem_size;
            if (status == iagc_ctrl_pkg::ST_SAMPLE && last_status != iagc_ctrl_pkg::ST_SAMPLE) begin
                valid_count  = 0;
                stored_words = 0;
            end
            if (status == iagc_ctrl_pkg::ST_DUMP && last_status != iagc_ctrl_pkg::ST_DUMP) begin
                dump_words = 0;
            end
            // first valid kept, then every dec-th one until the buffer is full
            if (status == iagc_ctrl_pkg::ST_SAMPLE && adc_valid) begin
                if ((valid_count % dec) == 0 && stored_words < size) begin
                    model_mem[iagc_data_pkg::ADDR_W'(stored_words)] = adc_data;
                    stored_words++;
                end
                valid_count++;
            end
            if (status == iagc_ctrl_pkg::ST_CLEAN) begin
                for (a = 0; a < size; a++) begin
                    model_mem[iagc_data_pkg::ADDR_W'(a)] = '0;
                end
            end
            if (dump_valid) begin
                assert (dump_words < size)
                else stop_with_failure("dump sent more words than the memory size");
                check_equal("dump word", int'(model_mem[iagc_data_pkg::ADDR_W'(dump_words)]),
                            int'(dump_data));
                dump_words++;
            end
            outstanding = sent_total - returned_total + (dump_valid ? 1 : 0);
            assert (outstanding <= iagc_data_pkg::DUMP_CREDITS)
            else stop_with_failure($sformatf(
                "MISMATCH %s credits outstanding: expected at most %0d, actual %0d",
                test_name, iagc_data_pkg::DUMP_CREDITS, outstanding));
            if (dump_valid) begin
                sent_total++;
            end
            // a return only counts while some credit is out
            if (dump_credit && outstanding > 0) begin
                returned_total++;
            end
        end
        last_status = status;
    end

    parse_then_read: assert property (@(negedge clock) disable iff (reset)
        status == iagc_ctrl_pkg::ST_CMD_PARSE |=> status == iagc_ctrl_pkg::ST_CMD_READ)
        else stop_with_failure($sformatf("MISMATCH %s after parse: expected %0d, actual %0d",
                                         test_name, iagc_ctrl_pkg::ST_CMD_READ, status));

    error_then_idle: assert property (@(negedge clock) disable iff (reset)
        status == iagc_ctrl_pkg::ST_CMD_ERROR |=> status == iagc_ctrl_pkg::ST_IDLE)
        else stop_with_failure($sformatf("MISMATCH %s after error: expected %0d, actual %0d",
                                         test_name, iagc_ctrl_pkg::ST_IDLE, status));

    halt_holds: assert property (@(negedge clock) disable iff (reset)
        status == iagc_ctrl_pkg::ST_HALT |=> status == iagc_ctrl_pkg::ST_HALT)
        else stop_with_failure($sformatf("MISMATCH %s in halt: expected %0d, actual %0d",
                                         test_name, iagc_ctrl_pkg::ST_HALT, status));

    initial begin : stimulus
        int k;
        test_name     = "reset_init";
        adc_enable    = 1'b0;
        credit_enable = 1'b0;
        exp_mem_size  = 64;
        exp_decimator = 4;
        reset         <= 1'b1;
        adc_init_done <= 1'b0;
        sample        <= 1'b0;
        cmd_valid     <= 1'b0;
        cmd_operation <= '0;
        cmd_parameter <= '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_status(iagc_ctrl_pkg::ST_RESET);
        for (k = 0; k < 6; k++) begin
            @(negedge clock);
            check_status(iagc_ctrl_pkg::ST_INIT);
        end
        @(posedge clock);
        adc_init_done <= 1'b1;
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 10);
        check_equal("memory size", 64, int'(memory_size));
        check_equal("decimator", 4, int'(decimator));

        test_name = "parameters";
        send_command(iagc_ctrl_pkg::CMD_SET_MEM, 4'd12);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 10);
        // exponent above the address width gives the full buffer
        exp_mem_size = 256;
        check_equal("memory size", exp_mem_size, int'(memory_size));
        send_command(iagc_ctrl_pkg::CMD_SET_MEM, 4'd4);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 10);
        exp_mem_size = 16;
        check_equal("memory size", exp_mem_size, int'(memory_size));
        send_command(iagc_ctrl_pkg::CMD_SET_DEC, 4'd3);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 10);
        exp_decimator = 3;
        check_equal("decimator", exp_decimator, int'(decimator));
        send_command(4'd9, 4'd5);
        wait_for_status(iagc_ctrl_pkg::ST_CMD_ERROR, 10);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 10);
        check_equal("memory size", 16, int'(memory_size));
        check_equal("decimator", 3, int'(decimator));

        test_name = "sample";
        @(posedge clock);
        sample <= 1'b1;
        @(posedge clock);
        sample <= 1'b0;
        wait_for_status(iagc_ctrl_pkg::ST_SAMPLE, 10);
        adc_enable = 1'b1;
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 1000);
        adc_enable = 1'b0;
        check_equal("stored words", 16, stored_words);

        // no credit returns, so the dump must stop after the initial credits
        test_name = "dump_stall";
        send_command(iagc_ctrl_pkg::CMD_DUMP, 4'd0);
        wait_for_dump_words(iagc_data_pkg::DUMP_CREDITS, 200);
        for (k = 0; k < 20; k++) begin
            @(negedge clock);
            check_equal("dump valid while stalled", 0, int'(dump_valid));
        end
        test_name = "dump_credits";
        credit_enable = 1'b1;
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 1000);
        check_equal("dump words", 16, dump_words);

        test_name = "clean";
        send_command(iagc_ctrl_pkg::CMD_CLEAN, 4'd0);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 200);
        send_command(iagc_ctrl_pkg::CMD_DUMP, 4'd0);
        wait_for_status(iagc_ctrl_pkg::ST_IDLE, 1000);
        check_equal("dump words", 16, dump_words);

        test_name = "halt";
        send_command(iagc_ctrl_pkg::CMD_HALT, 4'd0);
        wait_for_status(iagc_ctrl_pkg::ST_HALT, 10);
        for (k = 0; k < 4; k++) begin
            @(posedge clock);
            cmd_valid     <= 1'b1;
            cmd_operation <= iagc_ctrl_pkg::CMD_W'(k + 1);
            sample        <= 1'b1;
            @(posedge clock);
            cmd_valid     <= 1'b0;
            sample        <= 1'b0;
        end
        for (k = 0; k < 20; k++) begin
            @(negedge clock);
            check_status(iagc_ctrl_pkg::ST_HALT);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
hdl/iagc_ctrl_pkg.sv
hdl/iagc_data_pkg.sv
hdl/iagc_fsm.sv
hdl/sample_decimator.sv
hdl/sample_buffer.sv
hdl/dump_sender.sv
hdl/iagc_top.sv
verif/iagc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the acquisition controller testbench with Verilator.
# The exit status of the simulation binary reports pass or fail.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module iagc_tb \
    -f tb.f \
    -o iagc_sim

./obj_dir/iagc_sim
